/* include/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// datapath and address width
`define LSU_XLEN        32

// memory model depth in words, a power of two
`define LSU_MEM_WORDS   256

// op_type field of the control word
`define LSU_TYPE_MEM    4'd5
`define LSU_TYPE_ATOM   4'd6
`define LSU_TYPE_IBAR   4'd9

// subtypes of LSU_TYPE_MEM
`define LSU_SUB_LDB     5'd0
`define LSU_SUB_LDH     5'd1
`define LSU_SUB_LDW     5'd2
`define LSU_SUB_STB     5'd3
`define LSU_SUB_STH     5'd4
`define LSU_SUB_STW     5'd5
`define LSU_SUB_LDBU    5'd6
`define LSU_SUB_LDHU    5'd7
`define LSU_SUB_CACOP   5'd8

// subtypes of LSU_TYPE_ATOM
`define LSU_SUB_LL      5'd11
`define LSU_SUB_SC      5'd12

// cacop target, low bits of excp_arg
`define LSU_CACOP_ICACHE 3'd0
`define LSU_CACOP_DCACHE 3'd1
`define LSU_CACOP_L2     3'd2

`endif

/* logic/lsu_ctl_pkg.sv */
package lsu_ctl_pkg;

    // decoded control word as it leaves the decode stage
    typedef struct packed {
        logic [2:0]  rsvd_hi;   // bits 31:29
        logic        atom_hint; // bit 28
        logic [15:0] rsvd_mid;  // bits 27:12
        logic [4:0]  sub;       // subtype
        logic        rsvd_lo;   // bit 6
        logic        is_store;  // bit 5
        logic        is_load;   // bit 4
        logic [3:0]  op_type;   // bits 3:0
    } lsu_ctl_t;

    // cacop view of the opcode word
    typedef struct packed {
        logic        op_flag;   // always zero for cacop
        logic [14:0] rsvd;
        logic [15:0] arg;       // excp_arg passed through
    } cacop_word_t;

    // barrier view of the opcode word
    typedef struct packed {
        logic        barrier;   // set for ibar
        logic [30:0] rsvd;
    } ibar_word_t;

    // one opcode word, layout depends on the operation
    typedef union packed {
        cacop_word_t cacop;
        ibar_word_t  ibar;
    } cache_op_u;

endpackage

/* logic/lsu_mem_pkg.sv */
`include "lsu_defs.svh"

package lsu_mem_pkg;

    // request toward the data cache
    typedef struct packed {
        logic [`LSU_XLEN-1:0] addr;
        logic [`LSU_XLEN-1:0] wdata;     // already in lane position
        logic [3:0]           wstrb;
        logic [1:0]           size;      // 0 byte, 1 half, 2 word
        logic                 is_write;
        logic                 valid;
    } mem_req_t;

    // what the load formatter needs to know about a load
    typedef struct packed {
        logic [1:0] offset;    // low address bits
        logic [1:0] size;
        logic       is_signed;
        logic       is_load;
    } load_desc_t;

    // cache maintenance and barrier signals
    typedef struct packed {
        lsu_ctl_pkg::cache_op_u opcode;
        logic                   icache_op;
        logic                   dcache_op;
        logic                   l2cache_op;
        logic                   ifcacop_ibar;
    } cache_op_t;

endpackage

/* logic/cache_ctr.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module cache_ctr (
    input  logic                    stall,
    input  lsu_ctl_pkg::lsu_ctl_t   ctr,
    input  logic [`LSU_XLEN-1:0]    rrj,
    input  logic [`LSU_XLEN-1:0]    imm,
    input  logic [`LSU_XLEN-1:0]    rrd,
    input  logic [15:0]             excp_arg,
    output lsu_mem_pkg::mem_req_t   req,
    output lsu_mem_pkg::load_desc_t ld_desc,
    output lsu_mem_pkg::cache_op_t  cop_sig,
    output logic                    mmu_valid
);

    logic [`LSU_XLEN-1:0] addr;
    logic [1:0]           ofs;
    logic [4:0]           lane_sh;
    logic [3:0]           byte_strb;
    logic [3:0]           half_strb;
    logic                 half_ok;

    assign addr      = rrj + imm;
    assign ofs       = addr[1:0];
    assign lane_sh   = {ofs, 3'b000};       // byte offset in bits
    assign byte_strb = 4'b0001 << ofs;
    assign half_ok   = ~ofs[0];
    assign half_strb = half_ok ? (4'b0011 << ofs) : 4'b0000; // odd half gets no lanes

    always_comb begin
        req               = '0;
        req.addr          = addr;
        req.is_write      = ctr.is_store;
        req.valid         = ctr.is_store | ctr.is_load | ctr.atom_hint;
        ld_desc           = '0;
        ld_desc.offset    = ofs;
        cop_sig           = '0;
        mmu_valid         = ctr.is_store | ctr.is_load
                          | (ctr.atom_hint & (excp_arg[4:3] == 2'd2));
        if (ctr.op_type == `LSU_TYPE_MEM) begin
            case (ctr.sub)
                `LSU_SUB_LDB, `LSU_SUB_LDBU: begin
                    req.wstrb         = byte_strb;
                    ld_desc.is_load   = 1'b1;
                    ld_desc.is_signed = (ctr.sub == `LSU_SUB_LDB);
                end
                `LSU_SUB_LDH, `LSU_SUB_LDHU: begin
                    req.wstrb         = half_strb;
                    req.size          = 2'd1;
                    ld_desc.is_load   = 1'b1;
                    ld_desc.is_signed = (ctr.sub == `LSU_SUB_LDH);
                end
                `LSU_SUB_LDW: begin
                    req.wstrb         = 4'b1111;
                    req.size          = 2'd2;
                    ld_desc.is_load   = 1'b1;
                end
                `LSU_SUB_STB: begin
                    req.wstrb = byte_strb;
                    req.wdata = {24'b0, rrd[7:0]} << lane_sh;
                end
                `LSU_SUB_STH: begin
                    req.wstrb = half_strb;
                    req.size  = 2'd1;
                    req.wdata = half_ok ? ({16'b0, rrd[15:0]} << lane_sh) : '0;
                end
                `LSU_SUB_STW: begin
                    req.wstrb = 4'b1111;
                    req.size  = 2'd2;
                    req.wdata = rrd;
                end
                `LSU_SUB_CACOP: begin
                    case (excp_arg[2:0])
                        `LSU_CACOP_ICACHE: cop_sig.icache_op  = 1'b1;
                        `LSU_CACOP_DCACHE: cop_sig.dcache_op  = 1'b1;
                        `LSU_CACOP_L2:     cop_sig.l2cache_op = 1'b1;
                        default: ;                              // unknown target, no flag
                    endcase
                    cop_sig.opcode.cacop.op_flag = 1'b0;
                    cop_sig.opcode.cacop.arg     = excp_arg;
                    cop_sig.ifcacop_ibar         = ~stall;
                end
                default: ;
            endcase
        end else if (ctr.op_type == `LSU_TYPE_ATOM) begin
            case (ctr.sub)
                `LSU_SUB_LL: begin
                    req.wstrb       = 4'b1111;
                    req.size        = 2'd2;
                    ld_desc.is_load = 1'b1;
                end
                `LSU_SUB_SC: begin                      // no reservation check
                    req.wstrb = 4'b1111;
                    req.size  = 2'd2;
                    req.wdata = rrd;
                end
                default: ;
            endcase
        end else if (ctr.op_type == `LSU_TYPE_IBAR) begin
            cop_sig.opcode.ibar.barrier = 1'b1;
            cop_sig.icache_op           = 1'b1;
            cop_sig.ifcacop_ibar        = 1'b1;
        end
        ld_desc.size = req.size;
    end

endmodule

/* logic/dmem_model.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module dmem_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  lsu_mem_pkg::mem_req_t req,
    output logic [`LSU_XLEN-1:0]  rdata
);

    localparam int AW = $clog2(`LSU_MEM_WORDS);

    logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];
    logic [AW-1:0]        idx;

    // upper address bits are dropped, so the array wraps
    assign idx = req.addr[AW+1:2];

    always_ff @(posedge clk) begin
        if (req.valid && req.is_write) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wstrb[b]) begin
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    // whole word, lane selection happens in the formatter
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (req.valid && !req.is_write) begin
            rdata <= mem[idx];
        end
    end

endmodule

/* logic/load_align.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module load_align (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    in_valid,
    input  lsu_mem_pkg::load_desc_t ld_desc,
    input  logic [`LSU_XLEN-1:0]    rdata,
    output logic                    ld_valid,
    output logic [`LSU_XLEN-1:0]    ld_data
);

    import lsu_mem_pkg::*;

    load_desc_t           desc_q;
    logic [`LSU_XLEN-1:0] shifted;
    logic                 bad_half;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_valid <= 1'b0;
        end else begin
            ld_valid <= in_valid & ld_desc.is_load; // one cycle per load
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && ld_desc.is_load) begin
            desc_q <= ld_desc;
        end
    end

    assign shifted  = rdata >> {desc_q.offset, 3'b000};
    assign bad_half = (desc_q.size == 2'd1) && desc_q.offset[0];

    always_comb begin
        case (desc_q.size)
            2'd0: ld_data = {{(`LSU_XLEN-8){desc_q.is_signed & shifted[7]}}, shifted[7:0]};
            2'd1: begin
                if (bad_half) begin
                    ld_data = '0;                       // misaligned half reads as zero
                end else begin
                    ld_data = {{(`LSU_XLEN-16){desc_q.is_signed & shifted[15]}},
                               shifted[15:0]};
                end
            end
            default: ld_data = rdata;
        endcase
    end

endmodule

/* logic/lsu_top.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   in_valid,
    input  logic                   stall,
    input  lsu_ctl_pkg::lsu_ctl_t  ctr,
    input  logic [`LSU_XLEN-1:0]   rrj,
    input  logic [`LSU_XLEN-1:0]   imm,
    input  logic [`LSU_XLEN-1:0]   rrd,
    input  logic [15:0]            excp_arg,
    output logic                   ld_valid,
    output logic [`LSU_XLEN-1:0]   ld_data,
    output logic                   cop_valid,
    output lsu_mem_pkg::cache_op_t cop,
    output logic                   mmu_valid
);

    import lsu_mem_pkg::*;

    mem_req_t             req_raw;
    mem_req_t             req_mem;
    load_desc_t           ld_desc;
    cache_op_t            cop_sig;
    logic                 mmu_valid_c;
    logic                 cop_hit;
    logic [`LSU_XLEN-1:0] rdata;

    cache_ctr u_ctr (
        .stall     (stall),
        .ctr       (ctr),
        .rrj       (rrj),
        .imm       (imm),
        .rrd       (rrd),
        .excp_arg  (excp_arg),
        .req       (req_raw),
        .ld_desc   (ld_desc),
        .cop_sig   (cop_sig),
        .mmu_valid (mmu_valid_c)
    );

    always_comb begin
        req_mem       = req_raw;
        req_mem.valid = req_raw.valid & in_valid; // only on the strobe
    end

    dmem_model u_mem (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req_mem),
        .rdata (rdata)
    );

    load_align u_align (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .ld_desc  (ld_desc),
        .rdata    (rdata),
        .ld_valid (ld_valid),
        .ld_data  (ld_data)
    );

    assign cop_hit = cop_sig.icache_op | cop_sig.dcache_op | cop_sig.l2cache_op;

    // cache-op and mmu outputs live for one cycle after the strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cop_valid <= 1'b0;
            cop       <= '0;
            mmu_valid <= 1'b0;
        end else begin
            cop_valid <= in_valid & cop_hit;
            cop       <= in_valid ? cop_sig : '0;
            mmu_valid <= in_valid & mmu_valid_c;
        end
    end

endmodule

/* sim/lsu_tb.sv */
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_tb;

    import lsu_ctl_pkg::*;
    import lsu_mem_pkg::*;

    typedef struct packed {
        lsu_ctl_t    ctr;
        logic [31:0] rrj;
        logic [31:0] imm;
        logic [31:0] data_or;   // forced bits on top of random data
        logic [15:0] excp;
        logic        stall;
        logic        is_cop;
        logic        exp_cv;
        logic [3:0]  exp_flags; // icache, dcache, l2, ifcacop_ibar
        logic [31:0] exp_opc;
        logic        idle;      // no strobe in the following cycle
    } test_t;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    logic        stall;
    lsu_ctl_t    ctr;
    logic [31:0] rrj;
    logic [31:0] imm;
    logic [31:0] rrd;
    logic [15:0] excp_arg;
    logic        ld_valid;
    logic [31:0] ld_data;
    logic        cop_valid;
    cache_op_t   cop;
    logic        mmu_valid;

    test_t       tbl[$];
    string       names[$];
    logic [7:0]  shadow [1024];
    logic [31:0] lfsr_state;
    int          fails;
    int          passes;
    int          errors;

    lsu_top dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .stall     (stall),
        .ctr       (ctr),
        .rrj       (rrj),
        .imm       (imm),
        .rrd       (rrd),
        .excp_arg  (excp_arg),
        .ld_valid  (ld_valid),
        .ld_data   (ld_data),
        .cop_valid (cop_valid),
        .cop       (cop),
        .mmu_valid (mmu_valid)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // taps 32 22 2 1 with one step per bit
    task automatic rand_bits(input int n, output logic [31:0] val);
        logic fb;
        val = '0;
        for (int k = 0; k < n; k++) begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val        = {val[30:0], fb};
        end
    endtask

    function automatic lsu_ctl_t make_ctr(input logic [3:0] op, input logic [4:0] sub,
                                          input logic ld, input logic st);
        lsu_ctl_t c;
        c          = '0;
        c.op_type  = op;
        c.sub      = sub;
        c.is_load  = ld;
        c.is_store = st;
        return c;
    endfunction

    task automatic add_test(input string name, input lsu_ctl_t c, input logic [31:0] a,
                            input logic [31:0] b, input logic [31:0] dor,
                            input logic [15:0] ex, input logic st, input logic cp,
                            input logic cv, input logic [3:0] fl, input logic [31:0] opc);
        test_t t;
        t.ctr       = c;
        t.rrj       = a;
        t.imm       = b;
        t.data_or   = dor;
        t.excp      = ex;
        t.stall     = st;
        t.is_cop    = cp;
        t.exp_cv    = cv;
        t.exp_flags = fl;
        t.exp_opc   = opc;
        t.idle      = 1'b0;
        tbl.push_back(t);
        names.push_back(name);
    endtask

    task automatic add_mem(input string name, input logic [3:0] op, input logic [4:0] sub,
                           input logic ld, input logic st, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] dor);
        add_test(name, make_ctr(op, sub, ld, st), a, b, dor, 16'h0, 1'b0, 1'b0, 1'b0,
                 4'b0, 32'h0);
    endtask

    // the last entry gets an idle cycle after its result
    task automatic add_idle;
        test_t t;
        t      = tbl.pop_back();
        t.idle = 1'b1;
        tbl.push_back(t);
    endtask

    // reference for what a load must return
    function automatic logic [31:0] exp_load(input logic [9:0] a, input logic [1:0] size,
                                             input logic sgn);
        logic [9:0]  base;
        logic [15:0] h;
        base = {a[9:2], 2'b00};
        case (size)
            2'd0: exp_load = {{24{sgn & shadow[a][7]}}, shadow[a]};
            2'd1: begin
                h = {shadow[a + 10'd1], shadow[a]};
                exp_load = a[0] ? 32'h0 : {{16{sgn & h[15]}}, h};
            end
            default: exp_load = {shadow[base + 10'd3], shadow[base + 10'd2],
                                 shadow[base + 10'd1], shadow[base]};
        endcase
    endfunction

    task automatic store_shadow(input logic [9:0] a, input logic [1:0] size,
                                input logic [31:0] d);
        logic [9:0] base;
        base = {a[9:2], 2'b00};
        case (size)
            2'd0: shadow[a] = d[7:0];
            2'd1: begin
                if (!a[0]) begin // odd half writes nothing
                    shadow[a]         = d[7:0];
                    shadow[a + 10'd1] = d[15:8];
                end
            end
            default: begin
                for (int k = 0; k < 4; k++) begin
                    shadow[base + 10'(k)] = d[8*k +: 8];
                end
            end
        endcase
    endtask

    task automatic build_table;
        for (int w = 0; w < 8; w++) begin
            add_mem($sformatf("st_w init %0d", w), `LSU_TYPE_MEM, `LSU_SUB_STW, 1'b0, 1'b1,
                    32'(4 * w), 32'h0, 32'h0);
        end
        add_mem("st_b ofs0", `LSU_TYPE_MEM, `LSU_SUB_STB, 1'b0, 1'b1, 0, 0, 32'h0);
        add_mem("st_b ofs1", `LSU_TYPE_MEM, `LSU_SUB_STB, 1'b0, 1'b1, 0, 1, 32'h80);
        add_mem("st_b ofs2", `LSU_TYPE_MEM, `LSU_SUB_STB, 1'b0, 1'b1, 0, 2, 32'h0);
        add_mem("st_b ofs3", `LSU_TYPE_MEM, `LSU_SUB_STB, 1'b0, 1'b1, 8, 32'hffff_fffb, 0);
        add_mem("ld_w after st_b", `LSU_TYPE_MEM, `LSU_SUB_LDW, 1'b1, 1'b0, 0, 0, 0);
        add_mem("st_h ofs0", `LSU_TYPE_MEM, `LSU_SUB_STH, 1'b0, 1'b1, 4, 0, 32'h0);
        add_mem("st_h ofs2", `LSU_TYPE_MEM, `LSU_SUB_STH, 1'b0, 1'b1, 4, 2, 32'h8000);
        add_mem("ld_w after st_h", `LSU_TYPE_MEM, `LSU_SUB_LDW, 1'b1, 1'b0, 4, 0, 0);
        add_mem("st_h misaligned", `LSU_TYPE_MEM, `LSU_SUB_STH, 1'b0, 1'b1, 8, 1, 0);
        add_mem("ld_w after bad st_h", `LSU_TYPE_MEM, `LSU_SUB_LDW, 1'b1, 1'b0, 8, 0, 0);
        add_mem("ld_b ofs1", `LSU_TYPE_MEM, `LSU_SUB_LDB, 1'b1, 1'b0, 0, 1, 0);
        add_mem("ld_bu ofs1", `LSU_TYPE_MEM, `LSU_SUB_LDBU, 1'b1, 1'b0, 0, 1, 0);
        add_mem("ld_b ofs3", `LSU_TYPE_MEM, `LSU_SUB_LDB, 1'b1, 1'b0, 0, 3, 0);
        add_mem("ld_bu ofs2", `LSU_TYPE_MEM, `LSU_SUB_LDBU, 1'b1, 1'b0, 0, 2, 0);
        add_mem("ld_h ofs0", `LSU_TYPE_MEM, `LSU_SUB_LDH, 1'b1, 1'b0, 4, 0, 0);
        add_mem("ld_h ofs2", `LSU_TYPE_MEM, `LSU_SUB_LDH, 1'b1, 1'b0, 4, 2, 0);
        add_mem("ld_hu ofs2", `LSU_TYPE_MEM, `LSU_SUB_LDHU, 1'b1, 1'b0, 4, 2, 0);
        add_mem("ld_h misaligned", `LSU_TYPE_MEM, `LSU_SUB_LDH, 1'b1, 1'b0, 4, 1, 0);
        add_mem("ld_hu misaligned", `LSU_TYPE_MEM, `LSU_SUB_LDHU, 1'b1, 1'b0, 4, 3, 0);
        add_mem("ll", `LSU_TYPE_ATOM, `LSU_SUB_LL, 1'b1, 1'b0, 12, 0, 0);
        add_mem("sc", `LSU_TYPE_ATOM, `LSU_SUB_SC, 1'b0, 1'b1, 16, 0, 0);
        add_idle();
        add_mem("ld_w after sc", `LSU_TYPE_MEM, `LSU_SUB_LDW, 1'b1, 1'b0, 16, 0, 0);
        add_mem("ll after sc", `LSU_TYPE_ATOM, `LSU_SUB_LL, 1'b1, 1'b0, 12, 4, 0);
        add_mem("st_w ofs0", `LSU_TYPE_MEM, `LSU_SUB_STW, 1'b0, 1'b1, 20, 0, 32'h8000_0000);
        add_mem("ld_b ofs3 sign", `LSU_TYPE_MEM, `LSU_SUB_LDB, 1'b1, 1'b0, 20, 3, 0);
        add_idle();
        add_test("cacop icache", make_ctr(`LSU_TYPE_MEM, `LSU_SUB_CACOP, 1'b0, 1'b0), 0, 0, 0,
                 16'h1230, 1'b0, 1'b1, 1'b1, 4'b1001, 32'h0000_1230);
        add_test("cacop dcache stall", make_ctr(`LSU_TYPE_MEM, `LSU_SUB_CACOP, 1'b0, 1'b0),
                 0, 0, 0, 16'h00a9, 1'b1, 1'b1, 1'b1, 4'b0100, 32'h0000_00a9);
        add_test("cacop l2", make_ctr(`LSU_TYPE_MEM, `LSU_SUB_CACOP, 1'b0, 1'b0), 0, 0, 0,
                 16'hbeea, 1'b0, 1'b1, 1'b1, 4'b0011, 32'h0000_beea);
        add_test("cacop no target", make_ctr(`LSU_TYPE_MEM, `LSU_SUB_CACOP, 1'b0, 1'b0),
                 0, 0, 0, 16'h0005, 1'b0, 1'b1, 1'b0, 4'b0001, 32'h0000_0005);
        add_test("ibar", make_ctr(`LSU_TYPE_IBAR, 5'd0, 1'b0, 1'b0), 0, 0, 0, 16'h0,
                 1'b0, 1'b1, 1'b1, 4'b1001, 32'h8000_0000);
        add_idle();
    endtask

    task automatic check(input string sig, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %s got %h expected %h", sig, got, exp);
            errors++;
        end
    endtask

    task automatic run_test(input int i);
        test_t       t;
        logic [31:0] data;
        logic [31:0] addr;
        logic [31:0] exp_data;
        logic [31:0] opc;
        logic [1:0]  size;
        logic        sgn;
        logic        is_ld;
        logic        is_st;
        logic        done;
        logic        timed_out;
        int          cycles;
        t         = tbl[i];
        errors    = 0;
        rand_bits(32, data);
        data      = data | t.data_or;
        addr      = t.rrj + t.imm;
        is_ld     = t.ctr.is_load;
        is_st     = t.ctr.is_store;
        sgn       = (t.ctr.sub == `LSU_SUB_LDB) || (t.ctr.sub == `LSU_SUB_LDH);
        case (t.ctr.sub)
            `LSU_SUB_LDB, `LSU_SUB_LDBU, `LSU_SUB_STB: size = 2'd0;
            `LSU_SUB_LDH, `LSU_SUB_LDHU, `LSU_SUB_STH: size = 2'd1;
            default: size = 2'd2;
        endcase
        exp_data = is_ld ? exp_load(addr[9:0], size, sgn) : 32'h0;
        if (is_st) begin
            store_shadow(addr[9:0], size, data);
        end
        ctr      = t.ctr;
        rrj      = t.rrj;
        imm      = t.imm;
        rrd      = data;
        excp_arg = t.excp;
        stall    = t.stall;
        in_valid = 1'b1;
        cycles    = 0;
        done      = 1'b0;
        timed_out = 1'b0;
        while (!done) begin
            @(posedge clk);
            @(negedge clk);
            in_valid = 1'b0;
            cycles++;
            if (is_ld ? ld_valid : (t.exp_cv ? cop_valid : 1'b1)) begin
                done = 1'b1;
            end else if (cycles >= 8) begin
                $display("timeout: no result for test %0d after %0d cycles", i, cycles);
                errors++;
                timed_out = 1'b1;
                done      = 1'b1;
            end
        end
        if (!timed_out) begin
            if (cycles != 1) begin
                $display("result of test %0d came after %0d cycles instead of one", i, cycles);
                errors++;
            end
            check("ld_valid", 32'(ld_valid), 32'(is_ld));
            if (is_ld) begin
                check("ld_data", ld_data, exp_data);
            end
            check("cop_valid", 32'(cop_valid), 32'(t.exp_cv));
            check("mmu_valid", 32'(mmu_valid), 32'(is_ld | is_st));
            if (t.is_cop) begin
                opc = cop.opcode;
                check("cop.opcode", opc, t.exp_opc);
                check("cop flags", 32'({cop.icache_op, cop.dcache_op, cop.l2cache_op,
                      cop.ifcacop_ibar}), 32'(t.exp_flags));
            end
            if (t.idle) begin
                rrd = ~data; // new data shows a store that slips past the strobe
                @(posedge clk);
                @(negedge clk);
                check("ld_valid idle", 32'(ld_valid), 32'h0);
                check("cop_valid idle", 32'(cop_valid), 32'h0);
                check("mmu_valid idle", 32'(mmu_valid), 32'h0);
            end
        end
        if (errors == 0) begin
            passes++;
            $display("test %0d %s: pass", i, names[i]);
        end else begin
            fails++;
            $display("test %0d %s: fail", i, names[i]);
        end
    endtask

    initial begin
        lfsr_state = 32'hd15b;
        fails      = 0;
        passes     = 0;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        stall      = 1'b0;
        ctr        = '0;
        rrj        = '0;
        imm        = '0;
        rrd        = '0;
        excp_arg   = '0;
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        errors = 0;
        check("ld_valid after reset", 32'(ld_valid), 32'h0);
        check("cop_valid after reset", 32'(cop_valid), 32'h0);
        check("mmu_valid after reset", 32'(mmu_valid), 32'h0);
        if (errors == 0) begin
            passes++;
            $display("reset outputs: pass");
        end else begin
            fails++;
            $display("reset outputs: fail");
        end
        for (int i = 0; i < tbl.size(); i++) begin
            run_test(i);
        end
        $display("passed %0d, failed %0d", passes, fails);
        if (fails == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
+incdir+include
logic/lsu_ctl_pkg.sv
logic/lsu_mem_pkg.sv
logic/cache_ctr.sv
logic/dmem_model.sv
logic/load_align.sv
logic/lsu_top.sv
sim/lsu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module lsu_tb -f tb.f
out=$(./obj_dir/Vlsu_tb)
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED"
